//--- common/fb_pkg.sv
// ##########################################################
// 640x480 60 Hz timing with a 160x120 4-bit indexed framebuffer
// syncs are active low; coordinates start at the active area
// pipeline latency from coordinates to colour is fixed at 3
// ##########################################################

package fb_pkg;

    // horizontal timing in pixels
    localparam int H_ACTIVE = 640;
    localparam int H_FP     = 16;   // front porch
    localparam int H_SYNC   = 96;
    localparam int H_BP     = 48;   // back porch
    localparam int H_TOTAL  = H_ACTIVE + H_FP + H_SYNC + H_BP;  // 800

    // vertical timing in lines
    localparam int V_ACTIVE = 480;
    localparam int V_FP     = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BP     = 33;
    localparam int V_TOTAL  = V_ACTIVE + V_FP + V_SYNC + V_BP;  // 525

    // framebuffer geometry
    localparam int FB_WIDTH  = 160;
    localparam int FB_HEIGHT = 120;
    localparam int FB_PIXELS = FB_WIDTH * FB_HEIGHT;  // 19200
    localparam int FB_ADDRW  = $clog2(FB_PIXELS);     // 15 bits

    // coordinates to output pixel: addr reg, bram, clut
    localparam int PIPE_LAT = 3;

    // colour widths
    localparam int CHANW = 4;  // bits per channel
    localparam int CIDXW = 4;  // palette index, 16 colours

    typedef logic [9:0]          coord_t;    // screen x or y
    typedef logic [FB_ADDRW-1:0] fb_addr_t;  // framebuffer address
    typedef logic [CIDXW-1:0]    cidx_t;     // colour index
    typedef logic [CHANW-1:0]    chan_t;     // one colour channel

    // 12-bit rgb, red in the top nibble
    typedef struct packed {
        chan_t red;
        chan_t green;
        chan_t blue;
    } colr_t;

    // display control bundle
    typedef struct packed {
        logic hsync;  // active low
        logic vsync;  // active low
        logic de;     // active video
        logic frame;  // one cycle at (0,0)
    } disp_sync_t;

    // idle bundle, syncs inactive
    localparam disp_sync_t SYNC_IDLE = '{
        hsync: 1'b1,
        vsync: 1'b1,
        de:    1'b0,
        frame: 1'b0
    };

endpackage

//--- rtl/display_timing.sv
// ##########################################################
// 480p raster counters, all outputs registered and aligned
// sync bundle is decoded from the next count so it matches sx/sy
// frame pulse after reset comes with the next full frame
// ##########################################################

`timescale 1ns/1ps

module display_timing (
    input  logic               clk_pix,
    input  logic               rst,
    output fb_pkg::coord_t     sx,
    output fb_pkg::coord_t     sy,
    output fb_pkg::disp_sync_t sync
);

    fb_pkg::coord_t nx;  // next horizontal count
    fb_pkg::coord_t ny;  // next vertical count
    logic           line_end;

    always_comb begin
        line_end = (sx == fb_pkg::coord_t'(fb_pkg::H_TOTAL - 1));
        nx = line_end ? '0 : sx + 10'd1;
        if (!line_end) begin
            ny = sy;  // still on the same line
        end else if (sy == fb_pkg::coord_t'(fb_pkg::V_TOTAL - 1)) begin
            ny = '0;  // wrap to top of frame
        end else begin
            ny = sy + 10'd1;
        end
    end

    always_ff @(posedge clk_pix) begin
        if (rst) begin
            sx   <= '0;
            sy   <= '0;
            sync <= fb_pkg::SYNC_IDLE;
        end else begin
            sx <= nx;
            sy <= ny;
            // hsync low over 656..751
            sync.hsync <= !(nx >= fb_pkg::coord_t'(fb_pkg::H_ACTIVE + fb_pkg::H_FP) &&
                nx < fb_pkg::coord_t'(fb_pkg::H_ACTIVE + fb_pkg::H_FP + fb_pkg::H_SYNC));
            // vsync low over lines 490..491
            sync.vsync <= !(ny >= fb_pkg::coord_t'(fb_pkg::V_ACTIVE + fb_pkg::V_FP) &&
                ny < fb_pkg::coord_t'(fb_pkg::V_ACTIVE + fb_pkg::V_FP + fb_pkg::V_SYNC));
            sync.de    <= (nx < fb_pkg::coord_t'(fb_pkg::H_ACTIVE)) &&
                          (ny < fb_pkg::coord_t'(fb_pkg::V_ACTIVE));
            sync.frame <= (nx == '0) && (ny == '0);  // first visible pixel
        end
    end

    // active video never overlaps either sync pulse
    a_de_outside_sync : assert property (
        @(posedge clk_pix) disable iff (rst)
        sync.de |-> (sync.hsync && sync.vsync)
    );

endmodule

//--- framebuffer/fb_bram.sv
// ##########################################################
// simple dual-port ram, one clock, one index per pixel
// read data is registered; same-address read returns old data
// contents are undefined until written
// ##########################################################

`timescale 1ns/1ps

module fb_bram (
    input  logic             clk_pix,
    input  logic             we,
    input  fb_pkg::fb_addr_t addr_write,
    input  fb_pkg::cidx_t    data_in,
    input  fb_pkg::fb_addr_t addr_read,
    output fb_pkg::cidx_t    data_out
);

    // one colour index per framebuffer pixel
    fb_pkg::cidx_t mem [fb_pkg::FB_PIXELS];

    // write port
    always_ff @(posedge clk_pix) begin
        if (we) begin
            mem[addr_write] <= data_in;
        end
    end

    // read port, one cycle latency
    always_ff @(posedge clk_pix) begin
        data_out <= mem[addr_read];  // maps to block ram output reg
    end

endmodule

//--- framebuffer/fb_scan.sv
// ##########################################################
// raster read address for the 160x120 area at top left
// address is valid one cycle after its coordinate
// area flag leaves 2 cycles late, sync bundle 3 cycles late
// ##########################################################

`timescale 1ns/1ps

module fb_scan (
    input  logic               clk_pix,
    input  logic               rst,
    input  fb_pkg::coord_t     sx,
    input  fb_pkg::coord_t     sy,
    input  fb_pkg::disp_sync_t sync_in,
    output fb_pkg::fb_addr_t   fb_addr_read,
    output logic               paint_area,
    output fb_pkg::disp_sync_t sync_out
);

    logic                        area;    // current pixel inside framebuffer
    logic [fb_pkg::PIPE_LAT-2:0] area_q;  // matches addr + bram latency
    fb_pkg::disp_sync_t          sync_q [fb_pkg::PIPE_LAT];

    // de qualifies the area so blanking never paints
    always_comb begin
        area = sync_in.de &&
               (sx < fb_pkg::coord_t'(fb_pkg::FB_WIDTH)) &&
               (sy < fb_pkg::coord_t'(fb_pkg::FB_HEIGHT));
    end

    // address tracks the index of the last in-area pixel
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            fb_addr_read <= '0;
        end else if (sync_in.frame) begin
            fb_addr_read <= '0;  // pixel 0 of the image
        end else if (area) begin
            fb_addr_read <= fb_addr_read + 1'b1;
        end
    end

    // delay lines for area flag and sync bundle
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            area_q <= '0;
            for (int i = 0; i < fb_pkg::PIPE_LAT; i++) begin
                sync_q[i] <= fb_pkg::SYNC_IDLE;
            end
        end else begin
            area_q <= {area_q[fb_pkg::PIPE_LAT-3:0], area};
            sync_q[0] <= sync_in;
            for (int i = 1; i < fb_pkg::PIPE_LAT; i++) begin
                sync_q[i] <= sync_q[i-1];
            end
        end
    end

    assign paint_area = area_q[fb_pkg::PIPE_LAT-2];  // meets bram data
    assign sync_out   = sync_q[fb_pkg::PIPE_LAT-1];  // meets clut output

    // in-area reads never run past the end of the image
    a_addr_in_range : assert property (
        @(posedge clk_pix) disable iff (rst)
        area_q[0] |-> (fb_addr_read < fb_pkg::fb_addr_t'(fb_pkg::FB_PIXELS))
    );

endmodule

//--- rtl/clut.sv
// ##########################################################
// 16-entry writable palette, registered lookup
// output is black outside the painting area and during reset
// palette contents are undefined until written
// ##########################################################

`timescale 1ns/1ps

module clut (
    input  logic          clk_pix,
    input  logic          rst,
    input  logic          we,
    input  fb_pkg::cidx_t cidx_write,
    input  fb_pkg::colr_t colr_in,
    input  fb_pkg::cidx_t cidx_read,
    input  logic          paint_area,
    output fb_pkg::colr_t colr_out
);

    // one rgb entry per colour index
    fb_pkg::colr_t pal [2**fb_pkg::CIDXW];

    // palette write port
    always_ff @(posedge clk_pix) begin
        if (we) begin
            pal[cidx_write] <= colr_in;
        end
    end

    // lookup with blanking, one cycle latency
    always_ff @(posedge clk_pix) begin
        if (rst) begin
            colr_out <= '0;
        end else if (paint_area) begin
            colr_out <= pal[cidx_read];
        end else begin
            colr_out <= '0;  // border and blanking are black
        end
    end

endmodule

//--- rtl/fb_display.sv
// ##########################################################
// framebuffer pixel path, timing -> scan -> bram -> clut
// colour and sync leave together, 3 cycles after coordinates
// memories are loaded through the write ports only
// ##########################################################

`timescale 1ns/1ps

module fb_display (
    input  logic               clk_pix,
    input  logic               rst,
    input  logic               fb_we,
    input  fb_pkg::fb_addr_t   fb_addr_write,
    input  fb_pkg::cidx_t      fb_cidx_write,
    input  logic               pal_we,
    input  fb_pkg::cidx_t      pal_cidx_write,
    input  fb_pkg::colr_t      pal_colr_write,
    output fb_pkg::disp_sync_t sync,
    output fb_pkg::colr_t      colr
);

    fb_pkg::coord_t     sx;
    fb_pkg::coord_t     sy;
    fb_pkg::disp_sync_t tim_sync;      // aligned with sx/sy
    fb_pkg::fb_addr_t   fb_addr_read;
    fb_pkg::cidx_t      fb_cidx_read;  // one cycle after address
    logic               paint_area;

    display_timing u_timing (
        .clk_pix (clk_pix),
        .rst     (rst),
        .sx      (sx),
        .sy      (sy),
        .sync    (tim_sync)
    );

    fb_scan u_scan (
        .clk_pix      (clk_pix),
        .rst          (rst),
        .sx           (sx),
        .sy           (sy),
        .sync_in      (tim_sync),
        .fb_addr_read (fb_addr_read),
        .paint_area   (paint_area),
        .sync_out     (sync)
    );

    fb_bram u_bram (
        .clk_pix    (clk_pix),
        .we         (fb_we),
        .addr_write (fb_addr_write),
        .data_in    (fb_cidx_write),
        .addr_read  (fb_addr_read),
        .data_out   (fb_cidx_read)
    );

    clut u_clut (
        .clk_pix    (clk_pix),
        .rst        (rst),
        .we         (pal_we),
        .cidx_write (pal_cidx_write),
        .colr_in    (pal_colr_write),
        .cidx_read  (fb_cidx_read),
        .paint_area (paint_area),
        .colr_out   (colr)
    );

endmodule

//--- sim/tb_fb_display.sv
// ##########################################################
// directed testbench for the framebuffer pixel path
// outputs sampled on the falling edge and inputs driven on the rising
// model arrays mirror every write made to the DUT
// ##########################################################

`timescale 1ns/1ps

module tb_fb_display;

    localparam int FRAME_CYCLES = fb_pkg::H_TOTAL * fb_pkg::V_TOTAL;  // 420000
    localparam int MAX_CYCLES   = 5 * FRAME_CYCLES + 100_000;         // five frames plus margin
    localparam int FRAME_PIXELS = fb_pkg::H_ACTIVE * fb_pkg::V_ACTIVE;

    logic               clk_pix = 1'b0;
    logic               rst;
    logic               fb_we;
    fb_pkg::fb_addr_t   fb_addr_write;
    fb_pkg::cidx_t      fb_cidx_write;
    logic               pal_we;
    fb_pkg::cidx_t      pal_cidx_write;
    fb_pkg::colr_t      pal_colr_write;
    fb_pkg::disp_sync_t sync;
    fb_pkg::colr_t      colr;

    fb_pkg::cidx_t image [fb_pkg::FB_PIXELS];  // expected framebuffer
    fb_pkg::colr_t palette [16];               // expected palette
    int            cycles = 0;                 // rising edges since start

    fb_display dut (
        .clk_pix        (clk_pix),
        .rst            (rst),
        .fb_we          (fb_we),
        .fb_addr_write  (fb_addr_write),
        .fb_cidx_write  (fb_cidx_write),
        .pal_we         (pal_we),
        .pal_cidx_write (pal_cidx_write),
        .pal_colr_write (pal_colr_write),
        .sync           (sync),
        .colr           (colr)
    );

    always #5 clk_pix = ~clk_pix;  // 10 ns period

    always @(posedge clk_pix) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the DUT did not finish the frames", cycles);
            $display("STATUS: FAIL");
            $fatal(1, "run stopped by timeout");
        end
    end

    task automatic check(input string name, input logic [31:0] expected,
                         input logic [31:0] actual);
        if (actual !== expected) begin
            $display("Fail at %0t: %s expected %0h got %0h", $time, name, expected, actual);
            $display("STATUS: FAIL");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic check_idle_outputs();
        check("sync.hsync", 1, sync.hsync);  // inactive high
        check("sync.vsync", 1, sync.vsync);
        check("sync.de", 0, sync.de);
        check("sync.frame", 0, sync.frame);
        check("colr", 0, 32'(colr));
    endtask

    task automatic wait_frame();
        do begin
            @(negedge clk_pix);
        end while (!sync.frame);
    endtask

    task automatic write_pixel(input int addr, input fb_pkg::cidx_t idx);
        @(posedge clk_pix);
        fb_we         <= 1'b1;
        fb_addr_write <= fb_pkg::fb_addr_t'(addr);
        fb_cidx_write <= idx;
        image[addr] = idx;  // model follows the DUT write
    endtask

    task automatic write_palette(input int idx, input fb_pkg::colr_t c);
        @(posedge clk_pix);
        pal_we         <= 1'b1;
        pal_cidx_write <= fb_pkg::cidx_t'(idx);
        pal_colr_write <= c;
        palette[idx] = c;
    endtask

    task automatic release_write_strobes();
        @(posedge clk_pix);
        fb_we  <= 1'b0;
        pal_we <= 1'b0;
    endtask

    task automatic load_image();
        for (int a = 0; a < fb_pkg::FB_PIXELS; a++) begin
            write_pixel(a, fb_pkg::cidx_t'($urandom));
        end
        release_write_strobes();
    endtask

    task automatic load_palette();
        for (int i = 0; i < 16; i++) begin
            write_palette(i, fb_pkg::colr_t'(12'($urandom)));
        end
        release_write_strobes();
    endtask

    // reset levels, then first frame pulse one full frame plus latency later
    task automatic test_reset_state();
        int rel;
        @(posedge clk_pix);
        @(negedge clk_pix);
        check_idle_outputs();  // inside reset
        @(posedge clk_pix);
        rst <= 1'b0;
        for (int i = 0; i < fb_pkg::PIPE_LAT; i++) begin
            @(negedge clk_pix);
            if (i == 0) begin
                rel = cycles;  // edge that released reset
            end
            check_idle_outputs();  // pipeline still holds reset values
        end
        wait_frame();
        check("first frame delay", FRAME_CYCLES + fb_pkg::PIPE_LAT, cycles - rel);
        check("sync.de at frame", 1, sync.de);
    endtask

    // one whole frame from the current frame pulse
    task automatic check_sync_geometry();
        int de_cnt;
        int hs_cnt;
        int hs_first;
        int vs_lines;
        vs_lines = 0;
        for (int line = 0; line < fb_pkg::V_TOTAL; line++) begin
            de_cnt   = 0;
            hs_cnt   = 0;
            hs_first = -1;
            for (int x = 0; x < fb_pkg::H_TOTAL; x++) begin
                if (sync.de) de_cnt++;
                if (!sync.hsync) begin
                    if (hs_first < 0) hs_first = x;
                    hs_cnt++;
                end
                if (x == 0 && !sync.vsync) vs_lines++;  // vsync moves on line edges
                check("sync.frame", (line == 0 && x == 0), sync.frame);
                @(negedge clk_pix);
            end
            check("de cycles per line", (line < fb_pkg::V_ACTIVE) ? fb_pkg::H_ACTIVE : 0, de_cnt);
            check("hsync low cycles per line", fb_pkg::H_SYNC, hs_cnt);
            check("hsync start", fb_pkg::H_ACTIVE + fb_pkg::H_FP, hs_first);
        end
        check("vsync low lines", fb_pkg::V_SYNC, vs_lines);
        check("sync.frame after 525 lines", 1, sync.frame);  // next frame starts here
    endtask

    // full frame against the model with the black border
    task automatic check_frame();
        int            n;
        int            x;
        int            y;
        fb_pkg::colr_t expected;
        wait_frame();
        n = 0;
        while (n < FRAME_PIXELS) begin
            if (sync.de) begin
                x = n % fb_pkg::H_ACTIVE;
                y = n / fb_pkg::H_ACTIVE;
                expected = '0;  // border is black
                if (x < fb_pkg::FB_WIDTH && y < fb_pkg::FB_HEIGHT) begin
                    expected = palette[image[y * fb_pkg::FB_WIDTH + x]];
                end
                check("colr", 32'(expected), 32'(colr));
                check("sync.frame", (n == 0), sync.frame);
                n++;
            end else begin
                check("colr in blanking", 0, 32'(colr));
                check("sync.frame in blanking", 0, sync.frame);
            end
            if (n < FRAME_PIXELS) @(negedge clk_pix);
        end
    endtask

    task automatic test_image_readout();
        load_palette();
        load_image();
        check_frame();
    endtask

    // runs in vertical blanking right after check_frame
    task automatic test_live_update();
        int            idx;
        int            addr;
        fb_pkg::colr_t c;
        for (int i = 0; i < 4; i++) begin
            idx = i * 4 + $urandom_range(3, 0);  // one entry from each group of four
            c   = fb_pkg::colr_t'(12'(palette[idx]) ^ 12'($urandom_range(4095, 1)));
            write_palette(idx, c);  // always differs from the old colour
        end
        for (int i = 0; i < 32; i++) begin
            addr = $urandom_range(fb_pkg::FB_PIXELS - 1, 0);
            write_pixel(addr, image[addr] ^ fb_pkg::cidx_t'($urandom_range(15, 1)));
        end
        release_write_strobes();
        check_frame();
    endtask

    initial begin
        rst            = 1'b1;
        fb_we          = 1'b0;
        fb_addr_write  = '0;
        fb_cidx_write  = '0;
        pal_we         = 1'b0;
        pal_cidx_write = '0;
        pal_colr_write = '0;
        void'($urandom(32'h977a_91c4));  // fixed seed
        test_reset_state();
        check_sync_geometry();
        test_image_readout();
        test_live_update();
        $display("STATUS: PASS");
        $finish;
    end

endmodule

//--- list.f
common/fb_pkg.sv
rtl/display_timing.sv
framebuffer/fb_bram.sv
framebuffer/fb_scan.sv
rtl/clut.sv
rtl/fb_display.sv
sim/tb_fb_display.sv

//--- Makefile
# Verilator build and run of the framebuffer display testbench

TOP := tb_fb_display

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f list.f -Mdir obj_dir

# pass only if the run prints the pass line
run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "STATUS: PASS"

clean:
	rm -rf obj_dir
